// File: hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Instruction word and the fields the control unit looks at
    typedef logic [31:0] instr_t;                       // Whole registered instruction
    typedef logic [6:0]  opcode_t;                      // Bits 6 to 0
    typedef logic [2:0]  funct3_t;                      // Bits 14 to 12
    typedef logic [6:0]  funct7_t;                      // Bits 31 to 25
    typedef logic [5:0]  funct6_t;                      // Bits 31 to 26 of a shift immediate

    // Major opcodes
    localparam opcode_t op_r_type   = 7'd51;            // Register-register arithmetic
    localparam opcode_t op_i_arith  = 7'd19;            // Immediate arithmetic and shifts
    localparam opcode_t op_load     = 7'd3;             // All loads
    localparam opcode_t op_store    = 7'd35;            // All stores
    localparam opcode_t op_branch   = 7'd99;            // beq only
    localparam opcode_t op_jalr_bne = 7'd103;           // jalr, bne, blt and bge live here
    localparam opcode_t op_lui      = 7'd55;            // Upper immediate
    localparam opcode_t op_jal      = 7'd111;           // Jump and link

    // funct3 for arithmetic, shared by R-type and immediate forms
    localparam funct3_t f3_add_sub  = 3'd0;             // add, sub, addi
    localparam funct3_t f3_sll      = 3'd1;             // slli
    localparam funct3_t f3_slt      = 3'd2;             // slt, slti
    localparam funct3_t f3_srl_sra  = 3'd5;             // srli, srai
    localparam funct3_t f3_and      = 3'd7;             // and

    localparam funct3_t f3_ld_reserved = 3'd7;          // No load uses this code

    localparam funct3_t f3_sb = 3'd0;                   // Store byte
    localparam funct3_t f3_sh = 3'd1;                   // Store half
    localparam funct3_t f3_sw = 3'd2;                   // Store word
    localparam funct3_t f3_sd = 3'd7;                   // Store double

    localparam funct3_t f3_beq  = 3'd0;                 // Under op_branch
    localparam funct3_t f3_jalr = 3'd0;                 // Under op_jalr_bne
    localparam funct3_t f3_bne  = 3'd1;
    localparam funct3_t f3_blt  = 3'd4;
    localparam funct3_t f3_bge  = 3'd5;

    localparam funct7_t f7_base = 7'd0;                 // add, and, slt
    localparam funct7_t f7_alt  = 7'd32;                // sub

    // Upper bits of a shift immediate
    localparam funct6_t sh_logical = 6'd0;              // slli, srli
    localparam funct6_t sh_arith   = 6'd16;             // srai

endpackage

`default_nettype wire

// File: hdl/control_pkg.sv
`default_nettype none

package control_pkg;

    // Sequencer states, 0 is never entered
    typedef enum logic [1:0] {
        st_fetch  = 2'd1,                               // PC <= PC + 4
        st_decode = 2'd2,                               // Execute most instructions
        st_jump   = 2'd3                                // Second phase of branches and jumps
    } state_t;

    typedef logic [2:0] alu_op_t;                       // ALU function select
    localparam alu_op_t alu_pass_a = 3'd0;              // Result is operand A
    localparam alu_op_t alu_add    = 3'd1;
    localparam alu_op_t alu_sub    = 3'd2;
    localparam alu_op_t alu_and    = 3'd3;
    localparam alu_op_t alu_inc_a  = 3'd4;              // A + 1
    localparam alu_op_t alu_cmp    = 3'd7;              // Only updates the flags

    typedef logic mux_a_sel_t;                          // Upper ALU operand
    localparam mux_a_sel_t sel_a_pc  = 1'b0;
    localparam mux_a_sel_t sel_a_reg = 1'b1;            // Register A

    typedef logic [1:0] mux_b_sel_t;                    // Lower ALU operand
    localparam mux_b_sel_t sel_b_rs2         = 2'd0;    // Register B
    localparam mux_b_sel_t sel_b_four        = 2'd1;    // Constant 4
    localparam mux_b_sel_t sel_b_imm         = 2'd2;    // Sign-extended immediate
    localparam mux_b_sel_t sel_b_imm_shifted = 2'd3;    // Immediate times two

    typedef logic [1:0] shift_mode_t;
    localparam shift_mode_t shift_sll  = 2'd0;
    localparam shift_mode_t shift_srl  = 2'd1;
    localparam shift_mode_t shift_sra  = 2'd2;
    localparam shift_mode_t shift_none = 2'd3;          // Shifter passes data through

    typedef logic reg_src_t;                            // Register file write data
    localparam reg_src_t src_alu = 1'b0;
    localparam reg_src_t src_mem = 1'b1;

    // One value per supported instruction
    typedef enum logic [4:0] {
        cls_nop,
        cls_add, cls_sub, cls_and, cls_slt,
        cls_addi, cls_slti, cls_slli, cls_srli, cls_srai,
        cls_load, cls_store,
        cls_beq, cls_bne, cls_blt, cls_bge,
        cls_jal, cls_jalr,
        cls_lui
    } instr_class_t;

endpackage

`default_nettype wire

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import isa_pkg::*, control_pkg::*; (
    input  instr_t       instr,                         // Held stable for the whole instruction
    output instr_class_t instr_class,
    output logic         needs_jump                     // Instruction has a jump phase
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    funct6_t funct6;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign funct6 = instr[31:26];                       // Shift type lives above shamt

    always_comb begin
        instr_class = cls_nop;                          // Unknown words fall back to nop
        case (opcode)
            op_r_type: begin
                if (funct3 == f3_add_sub && funct7 == f7_base) begin
                    instr_class = cls_add;
                end else if (funct3 == f3_add_sub && funct7 == f7_alt) begin
                    instr_class = cls_sub;
                end else if (funct3 == f3_and && funct7 == f7_base) begin
                    instr_class = cls_and;
                end else if (funct3 == f3_slt && funct7 == f7_base) begin
                    instr_class = cls_slt;
                end
            end
            op_i_arith: begin
                if (instr[31:7] == 25'd0) begin
                    instr_class = cls_nop;              // addi x0, x0, 0
                end else if (funct3 == f3_add_sub) begin
                    instr_class = cls_addi;
                end else if (funct3 == f3_slt) begin
                    instr_class = cls_slti;
                end else if (funct3 == f3_sll && funct6 == sh_logical) begin
                    instr_class = cls_slli;
                end else if (funct3 == f3_srl_sra && funct6 == sh_logical) begin
                    instr_class = cls_srli;
                end else if (funct3 == f3_srl_sra && funct6 == sh_arith) begin
                    instr_class = cls_srai;
                end
            end
            op_load: begin
                if (funct3 != f3_ld_reserved) begin
                    instr_class = cls_load;             // Width is handled in the datapath
                end
            end
            op_store: begin
                if (funct3 inside {f3_sb, f3_sh, f3_sw, f3_sd}) begin
                    instr_class = cls_store;
                end
            end
            op_branch: begin
                if (funct3 == f3_beq) begin
                    instr_class = cls_beq;
                end
            end
            op_jalr_bne: begin
                case (funct3)
                    f3_jalr: instr_class = cls_jalr;
                    f3_bne:  instr_class = cls_bne;
                    f3_blt:  instr_class = cls_blt;
                    f3_bge:  instr_class = cls_bge;
                    default: instr_class = cls_nop;
                endcase
            end
            op_lui: begin
                instr_class = cls_lui;
            end
            op_jal: begin
                instr_class = cls_jal;
            end
            default: begin
                instr_class = cls_nop;                  // Includes the old break opcode
            end
        endcase
    end

    // Branches and jumps need a second cycle to load the PC
    assign needs_jump = instr_class inside {cls_beq, cls_bne, cls_blt, cls_bge,
                                            cls_jal, cls_jalr};

endmodule

`default_nettype wire

// File: hdl/control_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module control_sequencer import control_pkg::*; (
    input  logic   clock,
    input  logic   reset,                               // Async, active high
    input  logic   needs_jump,                          // From the decoder, valid in decode
    output state_t state
);

    state_t next_state;

    always_comb begin
        case (state)
            st_fetch: begin
                next_state = st_decode;                 // Always decode after fetch
            end
            st_decode: begin
                if (needs_jump) begin
                    next_state = st_jump;               // Branch, jal or jalr
                end else begin
                    next_state = st_fetch;              // Single-phase instruction done
                end
            end
            st_jump: begin
                next_state = st_fetch;
            end
            default: begin
                next_state = st_fetch;                  // Recover from the unused code
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

// File: hdl/datapath_control.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_control import control_pkg::*; (
    input  state_t       state,
    input  instr_class_t instr_class,
    input  logic         equal,                         // rs1 == rs2 from the ALU
    input  logic         less,                          // rs1 < rs2 from the ALU
    output logic         pc_write,
    output alu_op_t      alu_op,
    output mux_a_sel_t   mux_a_sel,
    output mux_b_sel_t   mux_b_sel,
    output shift_mode_t  shift_mode,
    output logic         reg_file_wr,
    output reg_src_t     reg_src,
    output logic         data_mem_wr,
    output logic         reset_a                        // Clears register A for slt
);

    logic branch_taken;

    // Branch outcome from the flags of the compare done in decode
    always_comb begin
        case (instr_class)
            cls_beq: branch_taken = equal;
            cls_bne: branch_taken = !equal;
            cls_blt: branch_taken = less;
            cls_bge: branch_taken = !less;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        // Inactive defaults, nothing is held from an earlier cycle
        pc_write    = 1'b0;
        alu_op      = alu_pass_a;
        mux_a_sel   = sel_a_pc;
        mux_b_sel   = sel_b_rs2;
        shift_mode  = shift_none;
        reg_file_wr = 1'b0;
        reg_src     = src_alu;
        data_mem_wr = 1'b0;
        reset_a     = 1'b0;

        case (state)
            st_fetch: begin
                pc_write  = 1'b1;                       // PC <= PC + 4
                alu_op    = alu_add;
                mux_a_sel = sel_a_pc;
                mux_b_sel = sel_b_four;
            end
            st_decode: begin
                case (instr_class)
                    cls_add: begin
                        alu_op      = alu_add;
                        mux_a_sel   = sel_a_reg;
                        mux_b_sel   = sel_b_rs2;
                        reg_file_wr = 1'b1;
                    end
                    cls_sub: begin
                        alu_op      = alu_sub;
                        mux_a_sel   = sel_a_reg;
                        mux_b_sel   = sel_b_rs2;
                        reg_file_wr = 1'b1;
                    end
                    cls_and: begin
                        alu_op      = alu_and;
                        mux_a_sel   = sel_a_reg;
                        mux_b_sel   = sel_b_rs2;
                        reg_file_wr = 1'b1;
                    end
                    cls_addi, cls_lui: begin
                        alu_op      = alu_add;          // lui adds the upper immediate to x0
                        mux_a_sel   = sel_a_reg;
                        mux_b_sel   = sel_b_imm;
                        reg_file_wr = 1'b1;
                    end
                    cls_slt, cls_slti: begin
                        reset_a     = 1'b1;             // A is zero, result is A or A + 1
                        alu_op      = less ? alu_inc_a : alu_pass_a;
                        mux_a_sel   = sel_a_reg;
                        mux_b_sel   = (instr_class == cls_slt) ? sel_b_rs2 : sel_b_imm;
                        reg_file_wr = 1'b1;
                    end
                    cls_slli, cls_srli, cls_srai: begin
                        case (instr_class)
                            cls_slli: shift_mode = shift_sll;
                            cls_srli: shift_mode = shift_srl;
                            default:  shift_mode = shift_sra;
                        endcase
                        alu_op      = alu_pass_a;       // Shifter does the work
                        mux_a_sel   = sel_a_reg;
                        reg_file_wr = 1'b1;
                    end
                    cls_load: begin
                        alu_op      = alu_add;          // Address rs1 + imm
                        mux_a_sel   = sel_a_reg;
                        mux_b_sel   = sel_b_imm;
                        reg_src     = src_mem;
                        reg_file_wr = 1'b1;
                    end
                    cls_store: begin
                        alu_op      = alu_add;
                        mux_a_sel   = sel_a_reg;
                        mux_b_sel   = sel_b_imm;
                        data_mem_wr = 1'b1;             // rs2 goes to memory
                    end
                    cls_beq, cls_bne, cls_blt, cls_bge: begin
                        alu_op    = alu_cmp;            // Sets equal and less for jump
                        mux_a_sel = sel_a_reg;
                        mux_b_sel = sel_b_rs2;
                    end
                    cls_jal, cls_jalr: begin
                        alu_op      = alu_pass_a;       // Return address is the current PC
                        mux_a_sel   = sel_a_pc;
                        reg_src     = src_alu;
                        reg_file_wr = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            st_jump: begin
                case (instr_class)
                    cls_beq, cls_bne, cls_blt, cls_bge: begin
                        if (branch_taken) begin
                            pc_write  = 1'b1;
                            alu_op    = alu_add;        // PC + offset
                            mux_a_sel = sel_a_pc;
                            mux_b_sel = sel_b_imm_shifted;
                        end
                    end
                    cls_jal: begin
                        pc_write  = 1'b1;
                        alu_op    = alu_add;
                        mux_a_sel = sel_a_pc;
                        mux_b_sel = sel_b_imm_shifted;
                    end
                    cls_jalr: begin
                        pc_write  = 1'b1;
                        alu_op    = alu_add;            // rs1 + imm
                        mux_a_sel = sel_a_reg;
                        mux_b_sel = sel_b_imm;
                    end
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import isa_pkg::*, control_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  instr_t       instr,                         // From the instruction register
    input  logic         equal,
    input  logic         less,
    output logic         pc_write,
    output alu_op_t      alu_op,
    output mux_a_sel_t   mux_a_sel,
    output mux_b_sel_t   mux_b_sel,
    output shift_mode_t  shift_mode,
    output logic         reg_file_wr,
    output reg_src_t     reg_src,
    output logic         data_mem_wr,
    output logic         reset_a,
    output state_t       state_code                     // Current sequencer state
);

    instr_class_t instr_class;
    logic         needs_jump;

    instr_decoder i_instr_decoder (
        .instr       (instr),
        .instr_class (instr_class),
        .needs_jump  (needs_jump)
    );

    control_sequencer i_control_sequencer (
        .clock      (clock),
        .reset      (reset),
        .needs_jump (needs_jump),
        .state      (state_code)
    );

    datapath_control i_datapath_control (
        .state       (state_code),
        .instr_class (instr_class),
        .equal       (equal),
        .less        (less),
        .pc_write    (pc_write),
        .alu_op      (alu_op),
        .mux_a_sel   (mux_a_sel),
        .mux_b_sel   (mux_b_sel),
        .shift_mode  (shift_mode),
        .reg_file_wr (reg_file_wr),
        .reg_src     (reg_src),
        .data_mem_wr (data_mem_wr),
        .reset_a     (reset_a)
    );

endmodule

`default_nettype wire

// File: tb/control_unit_chk.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit_chk import control_pkg::*; (
    input wire logic   clock,
    input wire logic   reset,
    input wire state_t state_code,
    input wire logic   pc_write,
    input wire logic   reg_file_wr,
    input wire logic   data_mem_wr,
    input wire logic   reset_a
);

    int fail_count;                                     // Read by the testbench at the end

    initial fail_count = 0;

    // One write strobe at a time
    no_double_write: assert property (@(posedge clock) disable iff (reset)
        !(data_mem_wr && reg_file_wr))
        else begin
            fail_count++;
            $error("register file and data memory written together");
        end

    fetch_loads_pc: assert property (@(posedge clock) disable iff (reset)
        (state_code == st_fetch) |-> pc_write)
        else begin
            fail_count++;
            $error("pc_write low in fetch");
        end

    jump_then_fetch: assert property (@(posedge clock) disable iff (reset)
        (state_code == st_jump) |=> (state_code == st_fetch))
        else begin
            fail_count++;
            $error("jump state not followed by fetch");
        end

    clear_a_in_decode: assert property (@(posedge clock) disable iff (reset)
        reset_a |-> (state_code == st_decode))
        else begin
            fail_count++;
            $error("reset_a high outside decode");
        end

endmodule

`default_nettype wire

// File: tb/control_unit_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit_monitor import isa_pkg::*, control_pkg::*; (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire instr_t      instr,
    input  wire logic        equal,
    input  wire logic        less,
    input  wire state_t      state_code,
    input  wire logic        pc_write,
    input  wire alu_op_t     alu_op,
    input  wire mux_a_sel_t  mux_a_sel,
    input  wire mux_b_sel_t  mux_b_sel,
    input  wire shift_mode_t shift_mode,
    input  wire logic        reg_file_wr,
    input  wire reg_src_t    reg_src,
    input  wire logic        data_mem_wr,
    input  wire logic        reset_a,
    output int               checks,                    // Compared values
    output int               errors                     // Mismatching values
);

    state_t      exp_state;                             // Model of the sequencer
    logic        e_pc;
    alu_op_t     e_alu;
    mux_a_sel_t  e_mux_a;
    mux_b_sel_t  e_mux_b;
    shift_mode_t e_shift;
    logic        e_rf_wr;
    reg_src_t    e_src;
    logic        e_dm_wr;
    logic        e_reset_a;

    initial begin
        checks = 0;
        errors = 0;
    end

    // Instruction classes straight from the encodings
    function automatic instr_class_t model_class(input instr_t w);
        instr_class_t c;
        c = cls_nop;                                    // Anything unknown
        case (w[6:0])
            7'd51: begin
                case ({w[31:25], w[14:12]})
                    {7'd0, 3'd0}:  c = cls_add;
                    {7'd32, 3'd0}: c = cls_sub;
                    {7'd0, 3'd7}:  c = cls_and;
                    {7'd0, 3'd2}:  c = cls_slt;
                    default:       c = cls_nop;
                endcase
            end
            7'd19: begin
                if (w[31:7] != 25'd0) begin             // All zero is the canonical nop
                    case (w[14:12])
                        3'd0: c = cls_addi;
                        3'd2: c = cls_slti;
                        3'd1: c = (w[31:26] == 6'd0) ? cls_slli : cls_nop;
                        3'd5: c = (w[31:26] == 6'd0) ? cls_srli :
                                  (w[31:26] == 6'd16) ? cls_srai : cls_nop;
                        default: c = cls_nop;
                    endcase
                end
            end
            7'd3:   c = (w[14:12] != 3'd7) ? cls_load : cls_nop;
            7'd35:  c = (w[14:12] inside {3'd0, 3'd1, 3'd2, 3'd7}) ? cls_store : cls_nop;
            7'd99:  c = (w[14:12] == 3'd0) ? cls_beq : cls_nop;
            7'd103: begin
                case (w[14:12])
                    3'd0: c = cls_jalr;
                    3'd1: c = cls_bne;
                    3'd4: c = cls_blt;
                    3'd5: c = cls_bge;
                    default: c = cls_nop;
                endcase
            end
            7'd55:  c = cls_lui;
            7'd111: c = cls_jal;
            default: c = cls_nop;
        endcase
        return c;
    endfunction

    // Expected controls for the current state, class and flags
    task automatic predict(input instr_class_t cls);
        logic taken;
        taken = (cls == cls_beq && equal) || (cls == cls_bne && !equal) ||
                (cls == cls_blt && less) || (cls == cls_bge && !less);
        e_pc = 1'b0;
        e_alu = alu_pass_a;
        e_mux_a = sel_a_pc;
        e_mux_b = sel_b_rs2;
        e_shift = shift_none;
        e_rf_wr = 1'b0;
        e_src = src_alu;
        e_dm_wr = 1'b0;
        e_reset_a = 1'b0;
        if (exp_state == st_fetch) begin
            e_pc = 1'b1;                                // PC + 4
            e_alu = alu_add;
            e_mux_b = sel_b_four;
        end else if (exp_state == st_decode) begin
            case (cls)
                cls_add, cls_sub, cls_and, cls_addi, cls_lui, cls_load, cls_store: begin
                    e_alu = (cls == cls_sub) ? alu_sub : (cls == cls_and) ? alu_and : alu_add;
                    e_mux_a = sel_a_reg;
                    e_mux_b = (cls inside {cls_add, cls_sub, cls_and}) ? sel_b_rs2 : sel_b_imm;
                    e_rf_wr = (cls != cls_store);
                    e_dm_wr = (cls == cls_store);
                    e_src = (cls == cls_load) ? src_mem : src_alu;
                end
                cls_slt, cls_slti: begin
                    e_reset_a = 1'b1;
                    e_alu = less ? alu_inc_a : alu_pass_a;
                    e_mux_a = sel_a_reg;
                    e_mux_b = (cls == cls_slt) ? sel_b_rs2 : sel_b_imm;
                    e_rf_wr = 1'b1;
                end
                cls_slli, cls_srli, cls_srai: begin
                    e_shift = (cls == cls_slli) ? shift_sll :
                              (cls == cls_srli) ? shift_srl : shift_sra;
                    e_mux_a = sel_a_reg;
                    e_rf_wr = 1'b1;
                end
                cls_beq, cls_bne, cls_blt, cls_bge: begin
                    e_alu = alu_cmp;                    // Compare rs1 with rs2
                    e_mux_a = sel_a_reg;
                end
                cls_jal, cls_jalr: e_rf_wr = 1'b1;      // Return address from the PC
                default: ;
            endcase
        end else if (exp_state == st_jump) begin
            if (taken || cls == cls_jal || cls == cls_jalr) begin
                e_pc = 1'b1;
                e_alu = alu_add;
                e_mux_a = (cls == cls_jalr) ? sel_a_reg : sel_a_pc;
                e_mux_b = (cls == cls_jalr) ? sel_b_imm : sel_b_imm_shifted;
            end
        end
    endtask

    task automatic compare_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            exp_state <= st_fetch;
        end else begin
            case (exp_state)
                st_fetch:  exp_state <= st_decode;
                st_decode: exp_state <= (model_class(instr) inside {cls_beq, cls_bne, cls_blt,
                                         cls_bge, cls_jal, cls_jalr}) ? st_jump : st_fetch;
                default:   exp_state <= st_fetch;
            endcase
        end
    end

    // Outputs are settled half a cycle after the inputs change
    always @(negedge clock) begin
        predict(model_class(instr));
        compare_value("state_code", 8'(exp_state), 8'(state_code));
        compare_value("pc_write", 8'(e_pc), 8'(pc_write));
        compare_value("alu_op", 8'(e_alu), 8'(alu_op));
        compare_value("mux_a_sel", 8'(e_mux_a), 8'(mux_a_sel));
        compare_value("mux_b_sel", 8'(e_mux_b), 8'(mux_b_sel));
        compare_value("shift_mode", 8'(e_shift), 8'(shift_mode));
        compare_value("reg_file_wr", 8'(e_rf_wr), 8'(reg_file_wr));
        compare_value("reg_src", 8'(e_src), 8'(reg_src));
        compare_value("data_mem_wr", 8'(e_dm_wr), 8'(data_mem_wr));
        compare_value("reset_a", 8'(e_reset_a), 8'(reset_a));
    end

endmodule

`default_nettype wire

// File: tb/tb_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_control_unit import isa_pkg::*, control_pkg::*; ();

    localparam int num_instrs   = 400;                  // Instructions per run
    localparam int clock_period = 40;

    logic        clock;
    logic        reset;
    instr_t      instr;
    logic        equal;
    logic        less;
    logic        pc_write;
    alu_op_t     alu_op;
    mux_a_sel_t  mux_a_sel;
    mux_b_sel_t  mux_b_sel;
    shift_mode_t shift_mode;
    logic        reg_file_wr;
    reg_src_t    reg_src;
    logic        data_mem_wr;
    logic        reset_a;
    state_t      state_code;
    int          checks;
    int          errors;
    integer      seed;
    int          applied;

    control_unit i_control_unit (
        .clock (clock), .reset (reset), .instr (instr), .equal (equal), .less (less),
        .pc_write (pc_write), .alu_op (alu_op), .mux_a_sel (mux_a_sel),
        .mux_b_sel (mux_b_sel), .shift_mode (shift_mode), .reg_file_wr (reg_file_wr),
        .reg_src (reg_src), .data_mem_wr (data_mem_wr), .reset_a (reset_a),
        .state_code (state_code)
    );

    control_unit_monitor i_control_unit_monitor (
        .clock (clock), .reset (reset), .instr (instr), .equal (equal), .less (less),
        .state_code (state_code), .pc_write (pc_write), .alu_op (alu_op),
        .mux_a_sel (mux_a_sel), .mux_b_sel (mux_b_sel), .shift_mode (shift_mode),
        .reg_file_wr (reg_file_wr), .reg_src (reg_src), .data_mem_wr (data_mem_wr),
        .reset_a (reset_a), .checks (checks), .errors (errors)
    );

    bind control_unit control_unit_chk i_control_unit_chk (
        .clock (clock), .reset (reset), .state_code (state_code), .pc_write (pc_write),
        .reg_file_wr (reg_file_wr), .data_mem_wr (data_mem_wr), .reset_a (reset_a)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Flags never claim equal and less at once
    task automatic drive_flags();
        logic [31:0] r;
        r = $random(seed);
        equal = r[0];
        less  = r[0] ? 1'b0 : r[1];
    endtask

    // Random instruction of a random class, with random fields
    function automatic instr_t random_instr();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        instr_t      w;
        r = $random(seed);
        s = $random(seed);
        rd = r[11:7];
        rs1 = r[19:15];
        rs2 = r[24:20];
        case (s % 21)
            2:  w = {7'd0, rs2, rs1, 3'd0, rd, 7'd51};                      // add
            3:  w = {7'd32, rs2, rs1, 3'd0, rd, 7'd51};                     // sub
            4:  w = {7'd0, rs2, rs1, 3'd7, rd, 7'd51};                      // and
            5:  w = {7'd0, rs2, rs1, 3'd2, rd, 7'd51};                      // slt
            6:  w = {r[31:20], rs1, 3'd0, rd, 7'd19};                       // addi
            7:  w = {r[31:20], rs1, 3'd2, rd, 7'd19};                       // slti
            8:  w = {6'd0, r[25:20], rs1, 3'd1, rd, 7'd19};                 // slli
            9:  w = {6'd0, r[25:20], rs1, 3'd5, rd, 7'd19};                 // srli
            10: w = {6'd16, r[25:20], rs1, 3'd5, rd, 7'd19};                // srai
            11: begin
                f3 = (s[31:29] == 3'd7) ? 3'd6 : s[31:29];                  // Load widths
                w = {r[31:20], rs1, f3, rd, 7'd3};
            end
            12: begin
                f3 = (s[31:30] == 2'd3) ? 3'd7 : {1'b0, s[31:30]};          // sb, sh, sw, sd
                w = {r[31:25], rs2, rs1, f3, r[11:7], 7'd35};
            end
            13: w = {r[31:25], rs2, rs1, 3'd0, r[11:7], 7'd99};             // beq
            14: w = {r[31:25], rs2, rs1, 3'd1, r[11:7], 7'd103};            // bne
            15: w = {r[31:25], rs2, rs1, 3'd4, r[11:7], 7'd103};            // blt
            16: w = {r[31:25], rs2, rs1, 3'd5, r[11:7], 7'd103};            // bge
            17: w = {r[31:7], 7'd111};                                     // jal
            18: w = {r[31:20], rs1, 3'd0, rd, 7'd103};                      // jalr
            19: w = {r[31:12], rd, 7'd55};                                  // lui
            20: w = {25'd0, 7'd19};                                         // nop
            default: w = r;                                                 // Any word at all
        endcase
        return w;
    endfunction

    // Watchdog sized for three cycles per instruction
    initial begin
        #(num_instrs * 3 * clock_period + 2000);
        $display("timeout, the instruction sequence did not complete in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        seed = 40;
        applied = 0;
        reset = 1'b1;
        instr = {25'd0, 7'd19};
        equal = 1'b0;
        less = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        while (applied < num_instrs) begin
            drive_flags();
            if (state_code == st_fetch) begin                               // Previous one done
                instr = random_instr();
                applied++;
            end
            @(posedge clock);
            #1;
        end
        while (state_code != st_fetch) begin                                // Let the last finish
            drive_flags();
            @(posedge clock);
            #1;
        end
        @(posedge clock);
        #1;
        $display("checks %0d, value errors %0d, assertion failures %0d", checks, errors,
                 i_control_unit.i_control_unit_chk.fail_count);
        if (errors == 0 && checks > 0 && i_control_unit.i_control_unit_chk.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/isa_pkg.sv
hdl/control_pkg.sv
hdl/instr_decoder.sv
hdl/control_sequencer.sv
hdl/datapath_control.sv
hdl/control_unit.sv
tb/control_unit_chk.sv
tb/control_unit_monitor.sv
tb/tb_control_unit.sv

// File: Makefile
TOP = tb_control_unit

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -qxF '** PASS **' sim.log

lint:
	verilator --lint-only -Wall hdl/isa_pkg.sv hdl/control_pkg.sv hdl/instr_decoder.sv \
		hdl/control_sequencer.sv hdl/datapath_control.sv hdl/control_unit.sv \
		--top-module control_unit

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
